//--- Alu.sv
`timescale 1ns/1ps
`default_nettype none

module Alu #(
    parameter int XLen = 32
) (
    input  wire logic [XLen-1:0]        a,
    input  wire logic [XLen-1:0]        b,
    input  wire ExecPkg::aluCtrl_t      op,
    output logic      [XLen-1:0]        result
);
    import ExecPkg::*;

    localparam int ShamtW = $clog2(XLen);

    logic [XLen-1:0]   addB;
    logic              subEn;
    logic [XLen-1:0]   sum;
    logic              carry;   // No borrow when set
    logic [XLen-1:0]   xorAB;
    logic [ShamtW-1:0] shamt;
    logic              isEq;
    logic              isLt;

    CarryLookaheadAdder #(
        .Width(XLen)
    ) adder (
        .a      (a),
        .b      (addB),
        .subEn  (subEn),
        .result (sum),
        .cout   (carry)
    );

    assign xorAB = a ^ b;
    assign shamt = b[ShamtW-1:0];
    assign isEq  = ~|xorAB;

    // Signs differ means a negative a is the smaller one
    assign isLt = (a[XLen-1] != b[XLen-1]) ? a[XLen-1] : sum[XLen-1];

    // ====================
    // Adder setup
    always_comb begin
        addB  = b;
        subEn = 1'b0;
        case (op)
            OP_SUB, OP_SLT, OP_SGTE, OP_SLTU, OP_SGTEU: subEn = 1'b1;
            OP_ADD4A: addB = XLen'(4);
            default: ;
        endcase
    end

    // ====================
    // Result select
    always_comb begin
        case (op)
            OP_AND:   result = a & b;
            OP_OR:    result = a | b;
            OP_XOR:   result = xorAB;
            OP_SLL:   result = a << shamt;
            OP_SRL:   result = a >> shamt;
            OP_SRA:   result = $signed(a) >>> shamt;
            OP_PASSB: result = b;
            OP_EQ:    result = XLen'(isEq);
            OP_NEQ:   result = XLen'(!isEq);
            OP_SLT:   result = XLen'(isLt);
            OP_SGTE:  result = XLen'(!isLt);
            OP_SLTU:  result = XLen'(!carry);
            OP_SGTEU: result = XLen'(carry);
            default:  result = sum;   // ADD, SUB, ADD4A
        endcase
    end

    opKnown: assert final ($isunknown({a, b}) || !$isunknown(op))
        else $error("ALU op unknown with known operands");

endmodule

`default_nettype wire

//--- Bender.yml
package:
  name: execute_stage

sources:
  - ExecPkg.sv
  - CarryLookaheadAdder.sv
  - Alu.sv
  - ExecControl.sv
  - OperandSelect.sv
  - ExMemRegister.sv
  - ExecuteStage.sv
  - target: test
    files:
      - tb_ExecuteStage.sv

//--- CarryLookaheadAdder.sv
`timescale 1ns/1ps
`default_nettype none

module CarryLookaheadAdder #(
    parameter int Width = 32
) (
    input  wire logic [Width-1:0] a,
    input  wire logic [Width-1:0] b,
    input  wire logic             subEn,   // Two's complement subtract
    output logic      [Width-1:0] result,
    output logic                  cout
);

    logic [Width-1:0] bIn;
    logic [Width-1:0] gen;
    logic [Width-1:0] prop;
    logic [Width:0]   carry;

    assign bIn      = subEn ? ~b : b;
    assign carry[0] = subEn;             // +1 completes the negation
    assign cout     = carry[Width];

    for (genvar i = 0; i < Width; i++) begin : gBit
        assign gen[i]     = a[i] & bIn[i];
        assign prop[i]    = a[i] ^ bIn[i];
        assign carry[i+1] = gen[i] | (prop[i] & carry[i]);
        assign result[i]  = prop[i] ^ carry[i];
    end

endmodule

`default_nettype wire

//--- ExMemRegister.sv
`timescale 1ns/1ps
`default_nettype none

module ExMemRegister #(
    parameter int XLen = 32
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              inValid,
    input  wire ExecPkg::regAddr_t rd,
    input  wire logic              regWrite,
    input  wire logic              isBranch,
    input  wire logic              isJump,
    input  wire logic [XLen-1:0]   aluResult,
    input  wire logic [XLen-1:0]   target,
    input  wire logic [XLen-1:0]   storeData,
    output logic                   outValid,
    output ExecPkg::regAddr_t      outRd,
    output logic                   outRegWrite,
    output logic                   outTakeBranch,
    output logic      [XLen-1:0]   outResult,
    output logic      [XLen-1:0]   outTarget,
    output logic      [XLen-1:0]   outStoreData
);

    logic takeBranch;

    // Compare result lands in bit 0 for branches
    assign takeBranch = inValid && (isJump || (isBranch && aluResult[0]));

    always_ff @(posedge clk) begin
        if (rst) begin
            outValid      <= 1'b0;
            outRd         <= '0;
            outRegWrite   <= 1'b0;
            outTakeBranch <= 1'b0;
            outResult     <= '0;
            outTarget     <= '0;
            outStoreData  <= '0;
        end else begin
            outValid      <= inValid;
            outRd         <= rd;
            outRegWrite   <= regWrite && inValid;   // Feeds MEM forwarding
            outTakeBranch <= takeBranch;
            outResult     <= aluResult;
            outTarget     <= target;
            outStoreData  <= storeData;
        end
    end

    takenIsValid: assert property (@(posedge clk) disable iff (rst)
        outTakeBranch |-> outValid)
        else $error("Branch taken without a valid instruction");

endmodule

`default_nettype wire

//--- ExecControl.sv
`timescale 1ns/1ps
`default_nettype none

module ExecControl (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              inValid,
    input  wire ExecPkg::aluOp_t   aluOp,
    input  wire ExecPkg::funct3_t  funct3,
    input  wire ExecPkg::funct7_t  funct7,
    input  wire ExecPkg::srcA_t    aluSrcA,
    input  wire ExecPkg::srcB_t    aluSrcB,
    input  wire ExecPkg::regAddr_t rs1Addr,
    input  wire ExecPkg::regAddr_t rs2Addr,
    input  wire ExecPkg::regAddr_t memRd,
    input  wire logic              memRegWrite,
    input  wire ExecPkg::regAddr_t wbRd,
    input  wire logic              wbRegWrite,
    output ExecPkg::aluCtrl_t      aluCtrl,
    output ExecPkg::fwdSel_t       fwdRs1,
    output ExecPkg::fwdSel_t       fwdRs2,
    output ExecPkg::srcA_t         selA,
    output ExecPkg::srcB_t         selB,
    output logic                   targetFromRs1,
    output logic                   isBranch,
    output logic                   isJump
);
    import ExecPkg::*;

    // ====================
    // ALU control decode
    always_comb begin
        aluCtrl = OP_ADD;   // Loads, stores, AUIPC, system, fence
        case (aluOp)
            ALU_OP_J, ALU_OP_I_JUMP: aluCtrl = OP_ADD4A;
            ALU_OP_U_LUI:            aluCtrl = OP_PASSB;
            ALU_OP_B: begin
                case (funct3)
                    3'b000:  aluCtrl = OP_EQ;
                    3'b001:  aluCtrl = OP_NEQ;
                    3'b100:  aluCtrl = OP_SLT;
                    3'b101:  aluCtrl = OP_SGTE;
                    3'b110:  aluCtrl = OP_SLTU;
                    3'b111:  aluCtrl = OP_SGTEU;
                    default: aluCtrl = OP_EQ;
                endcase
            end
            ALU_OP_I_ARITH: begin
                case (funct3)
                    3'b001:  aluCtrl = OP_SLL;
                    3'b010:  aluCtrl = OP_SLT;
                    3'b011:  aluCtrl = OP_SLTU;
                    3'b100:  aluCtrl = OP_XOR;
                    3'b101:  aluCtrl = funct7[5] ? OP_SRA : OP_SRL;
                    3'b110:  aluCtrl = OP_OR;
                    3'b111:  aluCtrl = OP_AND;
                    default: aluCtrl = OP_ADD;
                endcase
            end
            ALU_OP_R: begin
                case ({funct7, funct3})
                    10'b0100000_000: aluCtrl = OP_SUB;
                    10'b0000000_001: aluCtrl = OP_SLL;
                    10'b0000000_010: aluCtrl = OP_SLT;
                    10'b0000000_011: aluCtrl = OP_SLTU;
                    10'b0000000_100: aluCtrl = OP_XOR;
                    10'b0000000_101: aluCtrl = OP_SRL;
                    10'b0100000_101: aluCtrl = OP_SRA;
                    10'b0000000_110: aluCtrl = OP_OR;
                    10'b0000000_111: aluCtrl = OP_AND;
                    default:         aluCtrl = OP_ADD;
                endcase
            end
            default: ;
        endcase
    end

    // ====================
    // Operand sources and control flow
    always_comb begin
        selA = aluSrcA;
        selB = aluSrcB;
        case (aluOp)
            ALU_OP_R, ALU_OP_B: selB = SRC_B_RS2;
            ALU_OP_I_ARITH, ALU_OP_I_LOAD, ALU_OP_S, ALU_OP_U_LUI: selB = SRC_B_IMM;
            ALU_OP_J, ALU_OP_I_JUMP, ALU_OP_U_AUIPC: begin
                selA = SRC_A_PC;    // Return address or PC relative
                selB = SRC_B_IMM;
            end
            default: ;
        endcase
    end

    assign isBranch      = (aluOp == ALU_OP_B);
    assign isJump        = (aluOp == ALU_OP_J) || (aluOp == ALU_OP_I_JUMP);
    assign targetFromRs1 = (aluOp == ALU_OP_I_JUMP);   // JALR base

    // MEM forwarding has priority over WB
    assign fwdRs1 = (rs1Addr != '0 && memRegWrite && rs1Addr == memRd) ? FWD_MEM :
                    (rs1Addr != '0 && wbRegWrite  && rs1Addr == wbRd)  ? FWD_WB  : NO_FWD;
    assign fwdRs2 = (rs2Addr != '0 && memRegWrite && rs2Addr == memRd) ? FWD_MEM :
                    (rs2Addr != '0 && wbRegWrite  && rs2Addr == wbRd)  ? FWD_WB  : NO_FWD;

    ctrlKnown: assert property (@(posedge clk) disable iff (rst)
        inValid && !$isunknown({aluOp, funct3, funct7}) |-> !$isunknown(aluCtrl))
        else $error("Unknown ALU code for a decoded instruction");

    noFwdX0: assert property (@(posedge clk) disable iff (rst)
        inValid |-> (rs1Addr != '0 || fwdRs1 == NO_FWD) && (rs2Addr != '0 || fwdRs2 == NO_FWD))
        else $error("Forwarding selected for x0");

endmodule

`default_nettype wire

//--- ExecPkg.sv
`default_nettype none

package ExecPkg;

    // ====================
    // Field types
    typedef logic [4:0] regAddr_t;  // x0 is never forwarded
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;
    typedef logic [3:0] aluOp_t;    // Coarse class from decode
    typedef logic [4:0] aluCtrl_t;  // ALU operation code
    typedef logic [1:0] fwdSel_t;
    typedef logic       srcA_t;
    typedef logic       srcB_t;

    // ====================
    // Operation classes
    localparam aluOp_t ALU_OP_R       = 4'd0;
    localparam aluOp_t ALU_OP_I_ARITH = 4'd1;
    localparam aluOp_t ALU_OP_I_LOAD  = 4'd2;
    localparam aluOp_t ALU_OP_S       = 4'd3;
    localparam aluOp_t ALU_OP_B       = 4'd4;
    localparam aluOp_t ALU_OP_J       = 4'd5;
    localparam aluOp_t ALU_OP_I_JUMP  = 4'd6;   // JALR
    localparam aluOp_t ALU_OP_U_LUI   = 4'd7;
    localparam aluOp_t ALU_OP_U_AUIPC = 4'd8;
    localparam aluOp_t ALU_OP_I_SYS   = 4'd9;
    localparam aluOp_t ALU_OP_I_FENCE = 4'd10;

    // ====================
    // ALU operations
    localparam aluCtrl_t OP_ADD   = 5'd0;
    localparam aluCtrl_t OP_SUB   = 5'd1;
    localparam aluCtrl_t OP_AND   = 5'd2;
    localparam aluCtrl_t OP_OR    = 5'd3;
    localparam aluCtrl_t OP_XOR   = 5'd4;
    localparam aluCtrl_t OP_SLL   = 5'd5;
    localparam aluCtrl_t OP_SRL   = 5'd6;
    localparam aluCtrl_t OP_SRA   = 5'd7;
    localparam aluCtrl_t OP_PASSB = 5'd8;
    localparam aluCtrl_t OP_ADD4A = 5'd9;   // Return address
    localparam aluCtrl_t OP_EQ    = 5'd10;
    localparam aluCtrl_t OP_NEQ   = 5'd11;
    localparam aluCtrl_t OP_SLT   = 5'd12;
    localparam aluCtrl_t OP_SGTE  = 5'd13;
    localparam aluCtrl_t OP_SLTU  = 5'd14;
    localparam aluCtrl_t OP_SGTEU = 5'd15;

    // Forwarding sources
    localparam fwdSel_t NO_FWD  = 2'd0;
    localparam fwdSel_t FWD_MEM = 2'd1;
    localparam fwdSel_t FWD_WB  = 2'd2;

    // Operand sources
    localparam srcA_t SRC_A_RS1 = 1'b0;
    localparam srcA_t SRC_A_PC  = 1'b1;
    localparam srcB_t SRC_B_RS2 = 1'b0;
    localparam srcB_t SRC_B_IMM = 1'b1;

endpackage

`default_nettype wire

//--- ExecuteStage.sv
`timescale 1ns/1ps
`default_nettype none

module ExecuteStage #(
    parameter int XLen = 32
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              inValid,
    input  wire ExecPkg::aluOp_t   aluOp,
    input  wire ExecPkg::funct3_t  funct3,
    input  wire ExecPkg::funct7_t  funct7,
    input  wire ExecPkg::srcA_t    aluSrcA,
    input  wire ExecPkg::srcB_t    aluSrcB,
    input  wire ExecPkg::regAddr_t rs1Addr,
    input  wire ExecPkg::regAddr_t rs2Addr,
    input  wire ExecPkg::regAddr_t rd,
    input  wire logic              regWrite,
    input  wire logic [XLen-1:0]   rs1Data,
    input  wire logic [XLen-1:0]   rs2Data,
    input  wire logic [XLen-1:0]   pc,
    input  wire logic [XLen-1:0]   imm,
    input  wire ExecPkg::regAddr_t wbRd,
    input  wire logic              wbRegWrite,
    input  wire logic [XLen-1:0]   wbData,
    output logic                   outValid,
    output ExecPkg::regAddr_t      outRd,
    output logic                   outRegWrite,
    output logic                   outTakeBranch,
    output logic      [XLen-1:0]   outResult,
    output logic      [XLen-1:0]   outTarget,
    output logic      [XLen-1:0]   outStoreData
);
    import ExecPkg::*;

    aluCtrl_t        aluCtrl;
    fwdSel_t         fwdRs1;
    fwdSel_t         fwdRs2;
    srcA_t           selA;
    srcB_t           selB;
    logic            targetFromRs1;
    logic            isBranch;
    logic            isJump;
    logic [XLen-1:0] aluA;
    logic [XLen-1:0] aluB;
    logic [XLen-1:0] aluResult;
    logic [XLen-1:0] targetBase;
    logic [XLen-1:0] target;
    logic [XLen-1:0] storeData;

    // ====================
    // Decode and forwarding against our own EX/MEM register
    ExecControl control (
        .clk(clk), .rst(rst), .inValid(inValid),
        .aluOp(aluOp), .funct3(funct3), .funct7(funct7),
        .aluSrcA(aluSrcA), .aluSrcB(aluSrcB),
        .rs1Addr(rs1Addr), .rs2Addr(rs2Addr),
        .memRd(outRd), .memRegWrite(outRegWrite),
        .wbRd(wbRd), .wbRegWrite(wbRegWrite),
        .aluCtrl(aluCtrl), .fwdRs1(fwdRs1), .fwdRs2(fwdRs2),
        .selA(selA), .selB(selB), .targetFromRs1(targetFromRs1),
        .isBranch(isBranch), .isJump(isJump)
    );

    OperandSelect #(.XLen(XLen)) operands (
        .rs1Data(rs1Data), .rs2Data(rs2Data),
        .memResult(outResult), .wbData(wbData),
        .pc(pc), .imm(imm),
        .fwdRs1(fwdRs1), .fwdRs2(fwdRs2),
        .selA(selA), .selB(selB), .targetFromRs1(targetFromRs1),
        .aluA(aluA), .aluB(aluB), .targetBase(targetBase), .storeData(storeData)
    );

    // ====================
    // Datapath
    Alu #(.XLen(XLen)) alu (
        .a      (aluA),
        .b      (aluB),
        .op     (aluCtrl),
        .result (aluResult)
    );

    CarryLookaheadAdder #(.Width(XLen)) targetAdder (   // Branch and jump target
        .a      (targetBase),
        .b      (imm),
        .subEn  (1'b0),
        .result (target),
        .cout   ()
    );

    ExMemRegister #(.XLen(XLen)) exMem (
        .clk(clk), .rst(rst), .inValid(inValid),
        .rd(rd), .regWrite(regWrite),
        .isBranch(isBranch), .isJump(isJump),
        .aluResult(aluResult), .target(target), .storeData(storeData),
        .outValid(outValid), .outRd(outRd), .outRegWrite(outRegWrite),
        .outTakeBranch(outTakeBranch), .outResult(outResult),
        .outTarget(outTarget), .outStoreData(outStoreData)
    );

endmodule

`default_nettype wire

//--- OperandSelect.sv
`timescale 1ns/1ps
`default_nettype none

module OperandSelect #(
    parameter int XLen = 32
) (
    input  wire logic [XLen-1:0]   rs1Data,
    input  wire logic [XLen-1:0]   rs2Data,
    input  wire logic [XLen-1:0]   memResult,
    input  wire logic [XLen-1:0]   wbData,
    input  wire logic [XLen-1:0]   pc,
    input  wire logic [XLen-1:0]   imm,
    input  wire ExecPkg::fwdSel_t  fwdRs1,
    input  wire ExecPkg::fwdSel_t  fwdRs2,
    input  wire ExecPkg::srcA_t    selA,
    input  wire ExecPkg::srcB_t    selB,
    input  wire logic              targetFromRs1,
    output logic      [XLen-1:0]   aluA,
    output logic      [XLen-1:0]   aluB,
    output logic      [XLen-1:0]   targetBase,
    output logic      [XLen-1:0]   storeData
);
    import ExecPkg::*;

    logic [XLen-1:0] rs1Fwd;
    logic [XLen-1:0] rs2Fwd;

    function automatic logic [XLen-1:0] fwdMux(fwdSel_t sel, logic [XLen-1:0] regVal,
                                               logic [XLen-1:0] memVal,
                                               logic [XLen-1:0] wbVal);
        case (sel)
            FWD_MEM: return memVal;
            FWD_WB:  return wbVal;
            default: return regVal;
        endcase
    endfunction

    assign rs1Fwd = fwdMux(fwdRs1, rs1Data, memResult, wbData);
    assign rs2Fwd = fwdMux(fwdRs2, rs2Data, memResult, wbData);

    assign aluA       = (selA == SRC_A_PC)  ? pc  : rs1Fwd;
    assign aluB       = (selB == SRC_B_IMM) ? imm : rs2Fwd;
    assign targetBase = targetFromRs1 ? rs1Fwd : pc;
    assign storeData  = rs2Fwd;   // Forwarded store value

endmodule

`default_nettype wire

//--- sources.f
ExecPkg.sv
CarryLookaheadAdder.sv
Alu.sv
ExecControl.sv
OperandSelect.sv
ExMemRegister.sv
ExecuteStage.sv
tb_ExecuteStage.sv

//--- tb_ExecuteStage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ExecuteStage;
    import ExecPkg::*;

    localparam int XLen      = 32;
    localparam int NumCycles = 4000;
    localparam int MaxCycles = NumCycles + 100;   // Watchdog budget
    localparam int KindR     = 0;
    localparam int KindI     = 1;
    localparam int KindLoad  = 2;
    localparam int KindStore = 3;
    localparam int KindB     = 4;
    localparam int KindJal   = 5;
    localparam int KindJalr  = 6;
    localparam int KindLui   = 7;
    localparam int KindAuipc = 8;

    logic clk, rst, inValid, regWrite, wbRegWrite;
    aluOp_t aluOp;
    funct3_t funct3;
    funct7_t funct7;
    srcA_t aluSrcA;
    srcB_t aluSrcB;
    regAddr_t rs1Addr, rs2Addr, rd, wbRd;
    logic [XLen-1:0] rs1Data, rs2Data, pc, imm, wbData;
    logic outValid, outRegWrite, outTakeBranch;
    regAddr_t outRd;
    logic [XLen-1:0] outResult, outTarget, outStoreData;

    // Model state of the instruction in EX (exp) and of the one in EX/MEM (chk)
    logic expValid, expRegWrite, expTake, expHasResult;
    logic chkValid, chkRegWrite, chkTake, chkHasResult;
    regAddr_t expRd, chkRd;
    logic [XLen-1:0] expResult, expTarget, expStore;
    logic [XLen-1:0] chkResult, chkTarget, chkStore;
    int seed, errorCount, validCount, drainCount;
    logic [31:0] rnd;

    ExecuteStage #(.XLen(XLen)) dut (
        .clk(clk), .rst(rst), .inValid(inValid),
        .aluOp(aluOp), .funct3(funct3), .funct7(funct7),
        .aluSrcA(aluSrcA), .aluSrcB(aluSrcB),
        .rs1Addr(rs1Addr), .rs2Addr(rs2Addr), .rd(rd), .regWrite(regWrite),
        .rs1Data(rs1Data), .rs2Data(rs2Data), .pc(pc), .imm(imm),
        .wbRd(wbRd), .wbRegWrite(wbRegWrite), .wbData(wbData),
        .outValid(outValid), .outRd(outRd), .outRegWrite(outRegWrite),
        .outTakeBranch(outTakeBranch), .outResult(outResult),
        .outTarget(outTarget), .outStoreData(outStoreData)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ====================
    // Stimulus helpers
    function automatic logic [XLen-1:0] pickOperand();
        logic [31:0] r;
        r = $random(seed);
        case (r[3:0])   // Sign boundaries show up often
            4'd0:    return 32'h8000_0000;
            4'd1:    return 32'h7fff_ffff;
            4'd2:    return 32'hffff_ffff;
            4'd3:    return 32'h0000_0000;
            4'd4:    return 32'h0000_0001;
            default: return $random(seed);
        endcase
    endfunction

    function automatic regAddr_t pickReg();
        logic [31:0] r;
        r = $random(seed);
        return {3'b000, r[1:0]};   // x0..x3 keeps hazards frequent
    endfunction

    // Operand value after forwarding with MEM ahead of WB and x0 excluded
    function automatic logic [XLen-1:0] forwarded(regAddr_t src, logic [XLen-1:0] regVal);
        if (src != '0 && chkRegWrite && src == chkRd) return chkResult;
        if (src != '0 && wbRegWrite && src == wbRd) return wbData;
        return regVal;
    endfunction

    function automatic logic [XLen-1:0] arithResult(logic [2:0] f3, logic alt, logic isReg,
                                                    logic [XLen-1:0] a, logic [XLen-1:0] b);
        case (f3)
            3'b000: return (isReg && alt) ? a - b : a + b;
            3'b001: return a << b[4:0];
            3'b010: return {31'b0, $signed(a) < $signed(b)};
            3'b011: return {31'b0, a < b};
            3'b100: return a ^ b;
            3'b101: begin
                if (alt) return $signed(a) >>> b[4:0];
                return a >> b[4:0];
            end
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branchTaken(logic [2:0] f3, logic [XLen-1:0] a, logic [XLen-1:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic driveNext(input logic valid);
        logic [31:0] r;
        logic [XLen-1:0] a;
        logic [XLen-1:0] b;
        logic [XLen-1:0] base;
        int kind;
        {chkValid, chkRegWrite, chkTake, chkHasResult} =
            {expValid, expRegWrite, expTake, expHasResult};
        {chkRd, chkResult, chkTarget, chkStore} = {expRd, expResult, expTarget, expStore};
        r = $random(seed);
        wbRd = pickReg();
        wbRegWrite = r[9];
        wbData = pickOperand();
        kind = r[4:0] % 9;
        inValid = valid;
        rs1Addr = pickReg();
        rs2Addr = pickReg();
        rd = pickReg();
        rs1Data = pickOperand();
        rs2Data = pickOperand();
        pc = pickOperand() & 32'hffff_fffc;
        imm = pickOperand();
        funct3 = r[7:5];
        funct7 = '0;
        aluSrcA = SRC_A_RS1;
        aluSrcB = SRC_B_IMM;
        regWrite = 1'b1;
        a = forwarded(rs1Addr, rs1Data);
        b = forwarded(rs2Addr, rs2Data);
        base = pc;
        expTake = 1'b0;
        expHasResult = 1'b1;
        case (kind)
            KindR: begin
                aluOp = ALU_OP_R;
                aluSrcB = SRC_B_RS2;
                if (funct3 == 3'b000 || funct3 == 3'b101) funct7 = {1'b0, r[8], 5'b0};
                expResult = arithResult(funct3, funct7[5], 1'b1, a, b);
            end
            KindI: begin
                aluOp = ALU_OP_I_ARITH;
                if (funct3 == 3'b101) funct7 = {1'b0, r[8], 5'b0};   // SRAI
                expResult = arithResult(funct3, funct7[5], 1'b0, a, imm);
            end
            KindLoad: begin
                aluOp = ALU_OP_I_LOAD;
                expResult = a + imm;
            end
            KindStore: begin
                aluOp = ALU_OP_S;
                regWrite = 1'b0;
                expResult = a + imm;
            end
            KindB: begin
                aluOp = ALU_OP_B;
                aluSrcB = SRC_B_RS2;
                regWrite = 1'b0;
                if (funct3[2:1] == 2'b01) funct3[2] = 1'b1;   // No 010 or 011 branch
                expTake = branchTaken(funct3, a, b);
                expHasResult = 1'b0;
                expResult = '0;
            end
            KindJal, KindJalr: begin
                aluOp = (kind == KindJal) ? ALU_OP_J : ALU_OP_I_JUMP;
                aluSrcA = SRC_A_PC;
                expResult = pc + 4;
                expTake = 1'b1;
                if (kind == KindJalr) base = a;
            end
            KindLui: begin
                aluOp = ALU_OP_U_LUI;
                expResult = imm;
            end
            default: begin
                aluOp = ALU_OP_U_AUIPC;
                aluSrcA = SRC_A_PC;
                expResult = pc + imm;
            end
        endcase
        expValid = valid;
        expRd = rd;
        expRegWrite = regWrite && valid;
        expTake = expTake && valid;
        expTarget = base + imm;
        expStore = b;
        if (valid) validCount++;
    endtask

    task automatic reportMismatch(input string what, input logic [XLen-1:0] got,
                                  input logic [XLen-1:0] want);
        errorCount++;
        $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, want);
    endtask

    // ====================
    // Checks one cycle after each input
    ctrlOk: assert property (@(posedge clk) disable iff (rst)
        outValid == chkValid && outRegWrite == chkRegWrite && outTakeBranch == chkTake)
        else reportMismatch("valid/regWrite/take", XLen'($sampled({outValid, outRegWrite,
            outTakeBranch})), XLen'({chkValid, chkRegWrite, chkTake}));
    resultOk: assert property (@(posedge clk) disable iff (rst)
        chkValid && chkHasResult |-> outResult == chkResult)
        else reportMismatch("outResult", $sampled(outResult), chkResult);
    targetOk: assert property (@(posedge clk) disable iff (rst)
        chkValid |-> outTarget == chkTarget)
        else reportMismatch("outTarget", $sampled(outTarget), chkTarget);
    storeOk: assert property (@(posedge clk) disable iff (rst)
        chkValid |-> outStoreData == chkStore)
        else reportMismatch("outStoreData", $sampled(outStoreData), chkStore);
    rdOk: assert property (@(posedge clk) disable iff (rst)
        chkValid |-> outRd == chkRd)
        else reportMismatch("outRd", XLen'($sampled(outRd)), XLen'(chkRd));
    resetOk: assert property (@(posedge clk)
        rst |=> !outValid && !outRegWrite && !outTakeBranch && outResult == '0)
        else reportMismatch("output flags in reset", XLen'($sampled({outValid, outRegWrite,
            outTakeBranch})), '0);

    initial begin
        seed = 41402;
        errorCount = 0;
        validCount = 0;
        {expValid, expRegWrite, expTake, expHasResult} = '0;
        {expRd, expResult, expTarget, expStore} = '0;
        rst = 1'b1;
        driveNext(1'b0);   // Idle but known inputs during reset
        repeat (16) @(posedge clk);
        for (int i = 0; i < NumCycles; i++) begin
            @(negedge clk);
            rst = 1'b0;
            rnd = $random(seed);
            driveNext(rnd[2:0] != 3'b000);   // Some bubbles
        end
        drainCount = 0;
        do begin
            @(negedge clk);
            driveNext(1'b0);
            drainCount++;
        end while (outValid !== 1'b0 && drainCount < 20);
        if (outValid !== 1'b0) begin
            errorCount++;
            $display("outValid stayed high after the input stream ended");
        end
        @(negedge clk);
        $display("Checked %0d valid instructions in %0d cycles, %0d errors",
                 validCount, NumCycles, errorCount);
        if (errorCount == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(MaxCycles * 100);
        $display("Simulation did not finish within its time limit");
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire
